// ==== source/ifm_buf_pkg.sv ====
package ifm_buf_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int NUM_LANES   = 16;                // lanes per row.
    localparam int DATA_WIDTH  = 16;                // bits per activation.
    localparam int ROW_WIDTH   = NUM_LANES * DATA_WIDTH;
    localparam int FIFO_DEPTH  = 32;                // words per bank.
    localparam int PTR_WIDTH   = $clog2(FIFO_DEPTH);
    localparam int PIXEL_WIDTH = 14;
    localparam int TILE_WIDTH  = 14;
    localparam int OFM_WIDTH   = 9;
    localparam int SIZE_WIDTH  = 5;
    localparam int WINDOW      = 9;                 // 3x3 kernel window.
    localparam int PAD_KERNEL  = 3;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // padding actions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [1:0] PAD_PASS  = 2'd0;
    localparam logic [1:0] PAD_ZERO  = 2'd1;
    localparam logic [1:0] PAD_SHIFT = 2'd2;        // up one lane.
    localparam logic [1:0] PAD_TRUNC = 2'd3;        // drop highest valid lane.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef union packed {
        logic [ROW_WIDTH-1:0]                  word;  // flat bus view.
        logic [NUM_LANES-1:0][DATA_WIDTH-1:0]  lane;  // lane 0 in the low bits.
    } ifm_row_u;

    typedef struct packed {
        logic [1:0]            kernel_size;
        logic [3:0]            count_layer;
        logic [OFM_WIDTH-1:0]  ofm_size;
        logic [TILE_WIDTH-1:0] count_tiling;    // 1-based tile index.
        logic [SIZE_WIDTH-1:0] read_ifm_size;   // valid lanes in the row.
    } layer_cfg_t;

    typedef struct packed {
        logic                 rd_clr;
        logic                 wr_clr;
        logic                 wr_en;
        logic [NUM_LANES-1:0] rd_en;            // one strobe per lane.
    } bank_ctrl_t;

endpackage

// ==== source/ifm_pad_control.sv ====
module ifm_pad_control
    import ifm_buf_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  layer_cfg_t cfg,
    input  logic       ofm_read_en,
    output logic [1:0] pad_action
);

    logic [PIXEL_WIDTH-1:0] count_pixel;
    logic [3:0]             phase;
    logic [5:0]             tiles_per_line;
    logic [15:0]            last_col_start;
    logic [TILE_WIDTH-1:0]  t;
    logic [OFM_WIDTH-1:0]   t_mod_s;
    logic                   pad_active;
    logic                   is_first_line;
    logic                   is_inner_line;
    logic                   is_last_line;
    logic                   is_last_col;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pixel counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_pixel <= '0;
        end else if (ofm_read_en) begin
            count_pixel <= count_pixel + 1'b1;
        end else begin
            count_pixel <= '0;                      // restart window.
        end
    end

    assign phase = 4'(count_pixel % WINDOW);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tile position decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign t              = cfg.count_tiling;
    assign tiles_per_line = 6'((10'(cfg.ofm_size) + 10'(NUM_LANES - 1)) / NUM_LANES);
    assign last_col_start = 16'(cfg.ofm_size) * 16'(tiles_per_line - 6'd1) + 16'd1;
    assign t_mod_s        = (cfg.ofm_size != '0) ? OFM_WIDTH'(t % cfg.ofm_size) : '0;

    assign pad_active = (cfg.kernel_size == 2'(PAD_KERNEL)) &&
                        (cfg.count_layer > 4'd1) &&
                        (tiles_per_line >= 6'd2);

    assign is_first_line = (t == TILE_WIDTH'(1));
    assign is_inner_line = (t > TILE_WIDTH'(1)) && (t < TILE_WIDTH'(cfg.ofm_size));
    assign is_last_line  = (t == TILE_WIDTH'(cfg.ofm_size));
    assign is_last_col   = (16'(t) >= last_col_start);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // action decision, first matching tile row wins
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        pad_action = PAD_PASS;
        if (pad_active) begin
            if (is_first_line) begin
                if (phase inside {[1:3]}) begin
                    pad_action = PAD_ZERO;          // top border rows.
                end else if (phase inside {4, 7}) begin
                    pad_action = PAD_SHIFT;
                end
            end else if (is_inner_line) begin
                if (phase inside {1, 4, 7}) begin
                    pad_action = PAD_SHIFT;
                end
            end else if (is_last_line) begin
                if (phase inside {1, 4}) begin
                    pad_action = PAD_SHIFT;
                end else if (phase inside {0, 7, 8}) begin
                    pad_action = PAD_ZERO;          // bottom border rows.
                end
            end else if (is_last_col) begin
                if (t_mod_s == OFM_WIDTH'(1)) begin
                    if (phase inside {[1:3]}) begin
                        pad_action = PAD_ZERO;
                    end else if (phase inside {6, 0}) begin
                        pad_action = PAD_TRUNC;
                    end
                end else if (t_mod_s == '0) begin
                    if (phase inside {3, 6}) begin
                        pad_action = PAD_TRUNC;
                    end else if (phase inside {0, 7, 8}) begin
                        pad_action = PAD_ZERO;
                    end
                end else if (phase inside {3, 6, 0}) begin
                    pad_action = PAD_TRUNC;         // right border column.
                end
            end else begin
                if (t_mod_s == OFM_WIDTH'(1) && (phase inside {[1:3]})) begin
                    pad_action = PAD_ZERO;
                end else if (t_mod_s == '0 && (phase inside {0, 7, 8})) begin
                    pad_action = PAD_ZERO;
                end
            end
        end
    end

endmodule

// ==== source/ifm_pad_shaper.sv ====
module ifm_pad_shaper
    import ifm_buf_pkg::*;
(
    input  ifm_row_u              data_in,
    input  logic [SIZE_WIDTH-1:0] read_ifm_size,
    input  logic [1:0]            pad_action,
    output ifm_row_u              row_padded
);

    ifm_row_u masked;
    ifm_row_u shifted;
    ifm_row_u truncated;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lane masking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            if (k < int'(read_ifm_size)) begin
                masked.lane[k] = data_in.lane[k];
            end else begin
                masked.lane[k] = '0;                // lane beyond valid width.
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // padded variants of the masked row
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        shifted.lane[0] = '0;                       // left border pixel.
        for (int k = 1; k < NUM_LANES; k++) begin
            shifted.lane[k] = masked.lane[k-1];
        end
    end

    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            if (k == int'(read_ifm_size) - 1) begin
                truncated.lane[k] = '0;             // right border pixel.
            end else begin
                truncated.lane[k] = masked.lane[k];
            end
        end
    end

    always_comb begin
        case (pad_action)
            PAD_ZERO:  row_padded.word = '0;
            PAD_SHIFT: row_padded      = shifted;
            PAD_TRUNC: row_padded      = truncated;
            default:   row_padded      = masked;
        endcase
    end

endmodule

// ==== source/ifm_lane_fifo.sv ====
module ifm_lane_fifo
    import ifm_buf_pkg::*;
#(
    parameter int LANE = 0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  bank_ctrl_t            bank1,
    input  bank_ctrl_t            bank2,
    input  logic                  ifm_mux,
    input  logic [DATA_WIDTH-1:0] data_in,
    output logic [DATA_WIDTH-1:0] data_out
);

    bank_ctrl_t            ctrl    [2];
    logic [DATA_WIDTH-1:0] rd_word [2];

    assign ctrl[0] = bank1;
    assign ctrl[1] = bank2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // two identical banks, one fills while the other drains
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
        logic [PTR_WIDTH-1:0]  wr_ptr;
        logic [PTR_WIDTH-1:0]  rd_ptr;
        logic [DATA_WIDTH-1:0] rd_reg;
        logic                  rd_en;

        assign rd_en = ctrl[b].rd_en[LANE];

        always_ff @(posedge clk) begin
            if (ctrl[b].wr_en && !ctrl[b].wr_clr) begin
                mem[wr_ptr] <= data_in;
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                wr_ptr <= '0;
            end else if (ctrl[b].wr_clr) begin
                wr_ptr <= '0;
            end else if (ctrl[b].wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;            // wraps, oldest word lost.
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                rd_ptr <= '0;
                rd_reg <= '0;
            end else if (ctrl[b].rd_clr) begin
                rd_ptr <= '0;
            end else if (rd_en) begin
                rd_reg <= mem[rd_ptr];
                rd_ptr <= rd_ptr + 1'b1;
            end
        end

        assign rd_word[b] = rd_reg;
    end

    assign data_out = ifm_mux ? rd_word[1] : rd_word[0];   // bank 2 when high.

endmodule

// ==== source/ifm_fifo_array_top.sv ====
module ifm_fifo_array_top
    import ifm_buf_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  layer_cfg_t cfg,
    input  logic       ofm_read_en,
    input  bank_ctrl_t bank1,
    input  bank_ctrl_t bank2,
    input  logic       ifm_mux,
    input  ifm_row_u   data_in,
    output ifm_row_u   data_out
);

    logic [1:0] pad_action;
    ifm_row_u   row_padded;

    wire [NUM_LANES-1:0][DATA_WIDTH-1:0] lane_out;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // padding path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    ifm_pad_control u_pad_control (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .ofm_read_en (ofm_read_en),
        .pad_action  (pad_action)
    );

    ifm_pad_shaper u_pad_shaper (
        .data_in       (data_in),
        .read_ifm_size (cfg.read_ifm_size),
        .pad_action    (pad_action),
        .row_padded    (row_padded)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lane storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        ifm_lane_fifo #(
            .LANE (k)                           // picks rd_en[k] of each bank.
        ) u_lane_fifo (
            .clk      (clk),
            .rst_n    (rst_n),
            .bank1    (bank1),
            .bank2    (bank2),
            .ifm_mux  (ifm_mux),
            .data_in  (row_padded.lane[k]),
            .data_out (lane_out[k])
        );
    end

    assign data_out.lane = lane_out;

endmodule

// ==== bench/ifm_pad_checker.sv ====
module ifm_pad_checker
    import ifm_buf_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  layer_cfg_t             cfg,
    input  logic                   ofm_read_en,
    input  logic [1:0]             pad_action,
    input  logic [3:0]             phase,
    input  logic [PIXEL_WIDTH-1:0] count_pixel
);

    int fail_count = 0;                             // read by the testbench.

    shift_phase: assert property (@(posedge clk) disable iff (!rst_n)
        (pad_action == PAD_SHIFT) |-> (phase == 4'd1 || phase == 4'd4 || phase == 4'd7))
    else begin
        $error("shift action outside phases 1, 4 and 7");
        fail_count++;
    end

    pass_without_3x3: assert property (@(posedge clk) disable iff (!rst_n)
        (cfg.kernel_size != 2'(PAD_KERNEL)) |-> (pad_action == PAD_PASS))
    else begin
        $error("padding applied with a kernel size other than 3");
        fail_count++;
    end

    counter_restart: assert property (@(posedge clk) disable iff (!rst_n)
        !ofm_read_en |=> (count_pixel == '0))
    else begin
        $error("pixel counter not zero after ofm_read_en was low");
        fail_count++;
    end

endmodule

bind ifm_pad_control ifm_pad_checker u_pad_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg         (cfg),
    .ofm_read_en (ofm_read_en),
    .pad_action  (pad_action),
    .phase       (phase),
    .count_pixel (count_pixel)
);

// ==== bench/tb_ifm_fifo_array.sv ====
module tb_ifm_fifo_array
    import ifm_buf_pkg::*;
();

    localparam int MAX_CYCLES = 3000;   // tests run a few hundred cycles, wide margin.

    logic       clk = 1'b0;
    logic       rst_n;
    layer_cfg_t cfg;
    logic       ofm_read_en;
    bank_ctrl_t bank1;
    bank_ctrl_t bank2;
    logic       ifm_mux;
    ifm_row_u   data_in;
    ifm_row_u   data_out;

    int unsigned          lcg_state;
    int                   run_len;          // consecutive earlier cycles with ofm_read_en high.
    int                   cycle_count = 0;
    int                   check_count;
    int                   error_count;
    int                   test_count;
    logic [ROW_WIDTH-1:0] exp_q1 [$];
    logic [ROW_WIDTH-1:0] exp_q2 [$];

    ifm_fifo_array_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .ofm_read_en (ofm_read_en),
        .bank1       (bank1),
        .bank2       (bank2),
        .ifm_mux     (ifm_mux),
        .data_in     (data_in),
        .data_out    (data_out)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    function automatic logic [ROW_WIDTH-1:0] random_row();
        logic [ROW_WIDTH-1:0] row;
        for (int k = 0; k < NUM_LANES; k++) begin
            row[k*DATA_WIDTH +: DATA_WIDTH] = lcg_next();
        end
        return row;
    endfunction

    function automatic bit in_set(logic [8:0] set, int phase);
        return ((set >> phase) & 9'd1) != 9'd0;     // bit p stands for phase p.
    endfunction

    function automatic logic [1:0] expected_action(layer_cfg_t c, int phase);
        int         s;
        int         t;
        int         tiles;
        int         t_mod;
        logic [8:0] zero_set;
        logic [8:0] shift_set;
        logic [8:0] trunc_set;
        s = int'(c.ofm_size);
        t = int'(c.count_tiling);
        tiles = (s + NUM_LANES - 1) / NUM_LANES;
        t_mod = (s == 0) ? 0 : t % s;
        zero_set = '0;
        shift_set = '0;
        trunc_set = '0;
        if (c.kernel_size != 2'(PAD_KERNEL) || c.count_layer <= 4'd1 || tiles < 2) begin
            return PAD_PASS;
        end
        if (t == 1) begin
            zero_set = 9'b000001110;
            shift_set = 9'b010010000;
        end else if (t > 1 && t < s) begin
            shift_set = 9'b010010010;
        end else if (t == s) begin
            shift_set = 9'b000010010;
            zero_set = 9'b110000001;
        end else if (t >= s * (tiles - 1) + 1) begin
            if (t_mod == 1) begin
                zero_set = 9'b000001110;
                trunc_set = 9'b001000001;
            end else if (t_mod == 0) begin
                trunc_set = 9'b001001000;
                zero_set = 9'b110000001;
            end else begin
                trunc_set = 9'b001001001;
            end
        end else if (t_mod == 1) begin
            zero_set = 9'b000001110;
        end else if (t_mod == 0) begin
            zero_set = 9'b110000001;
        end
        if (in_set(zero_set, phase)) begin
            return PAD_ZERO;
        end else if (in_set(shift_set, phase)) begin
            return PAD_SHIFT;
        end else if (in_set(trunc_set, phase)) begin
            return PAD_TRUNC;
        end
        return PAD_PASS;
    endfunction

    function automatic logic [ROW_WIDTH-1:0] expected_row(layer_cfg_t c, int phase,
                                                          logic [ROW_WIDTH-1:0] row);
        logic [ROW_WIDTH-1:0] masked;
        logic [ROW_WIDTH-1:0] result;
        logic [1:0]           action;
        int                   size;
        size = int'(c.read_ifm_size);
        action = expected_action(c, phase);
        masked = '0;
        result = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            if (k < size) begin
                masked[k*DATA_WIDTH +: DATA_WIDTH] = row[k*DATA_WIDTH +: DATA_WIDTH];
            end
        end
        for (int k = 0; k < NUM_LANES; k++) begin
            if (action == PAD_PASS || (action == PAD_TRUNC && k != size - 1)) begin
                result[k*DATA_WIDTH +: DATA_WIDTH] = masked[k*DATA_WIDTH +: DATA_WIDTH];
            end else if (action == PAD_SHIFT && k > 0) begin
                result[k*DATA_WIDTH +: DATA_WIDTH] = masked[(k-1)*DATA_WIDTH +: DATA_WIDTH];
            end
        end
        return result;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // driver tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic tick();
        @(posedge clk);
        run_len = ofm_read_en ? run_len + 1 : 0;    // mirrors the pixel counter.
        #1;
    endtask

    task automatic check_value(string name, logic [ROW_WIDTH-1:0] got,
                               logic [ROW_WIDTH-1:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic clear_banks();
        ofm_read_en = 1'b0;
        bank1 = '{rd_clr: 1'b1, wr_clr: 1'b1, wr_en: 1'b0, rd_en: '0};
        bank2 = '{rd_clr: 1'b1, wr_clr: 1'b1, wr_en: 1'b0, rd_en: '0};
        tick();
        bank1 = '0;
        bank2 = '0;
        exp_q1.delete();
        exp_q2.delete();
    endtask

    task automatic write_row(int bank, logic [ROW_WIDTH-1:0] row, logic read_en);
        data_in.word = row;
        ofm_read_en = read_en;
        if (bank == 1) begin
            bank1.wr_en = 1'b1;
            exp_q1.push_back(expected_row(cfg, run_len % WINDOW, row));
        end else begin
            bank2.wr_en = 1'b1;
            exp_q2.push_back(expected_row(cfg, run_len % WINDOW, row));
        end
        tick();
        bank1.wr_en = 1'b0;
        bank2.wr_en = 1'b0;
    endtask

    task automatic read_check(int bank);
        logic [ROW_WIDTH-1:0] expected;
        ifm_mux = (bank == 2);
        if (bank == 1) begin
            bank1.rd_en = '1;
            expected = exp_q1.pop_front();
        end else begin
            bank2.rd_en = '1;
            expected = exp_q2.pop_front();
        end
        tick();                                     // word shows one cycle after the strobe.
        bank1.rd_en = '0;
        bank2.rd_en = '0;
        check_value("data_out", data_out.word, expected);
    endtask

    task automatic padded_window(int rows);
        clear_banks();
        repeat (rows) write_row(1, random_row(), 1'b1);
        ofm_read_en = 1'b0;
        repeat (rows) read_check(1);
    endtask

    task automatic finish_test(string name, int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_masking();
        int errors_before;
        int size_list [3] = '{0, 5, 16};
        errors_before = error_count;
        cfg = '0;                                   // kernel size 0, no padding.
        for (int i = 0; i < 3; i++) begin
            cfg.read_ifm_size = 5'(size_list[i]);
            clear_banks();
            repeat (4) write_row(1, random_row(), 1'b0);
            repeat (4) read_check(1);
        end
        finish_test("masking", errors_before);
    endtask

    task automatic test_ping_pong();
        int                   errors_before;
        logic [ROW_WIDTH-1:0] first_row;
        logic [ROW_WIDTH-1:0] last_row;
        errors_before = error_count;
        cfg = '0;
        cfg.read_ifm_size = 5'd16;
        clear_banks();
        for (int i = 0; i < 4; i++) begin
            write_row(1, random_row(), 1'b0);
            write_row(2, random_row(), 1'b0);
        end
        first_row = exp_q1[0];
        last_row = exp_q1[3];
        repeat (4) read_check(1);
        repeat (4) read_check(2);
        ifm_mux = 1'b0;
        bank1.rd_clr = 1'b1;
        tick();
        bank1.rd_clr = 1'b0;
        check_value("data_out", data_out.word, last_row);
        bank1.rd_en = 16'h00ff;                     // low lanes restart, high lanes hold.
        tick();
        bank1.rd_en = '0;
        check_value("data_out", data_out.word,
                    {last_row[ROW_WIDTH-1:ROW_WIDTH/2], first_row[ROW_WIDTH/2-1:0]});
        bank1.rd_en = 16'hff00;
        tick();
        bank1.rd_en = '0;
        check_value("data_out", data_out.word, first_row);
        write_row(2, random_row(), 1'b0);           // bank 2 pointers now differ.
        bank2 = '{rd_clr: 1'b1, wr_clr: 1'b1, wr_en: 1'b0, rd_en: '0};
        tick();
        bank2 = '0;
        exp_q2.delete();
        write_row(2, random_row(), 1'b0);
        read_check(2);
        finish_test("ping_pong", errors_before);
    endtask

    task automatic run_tiles(string name, int size, int tile_list [3]);
        int errors_before;
        errors_before = error_count;
        cfg = '{kernel_size: 2'd3, count_layer: 4'd2, ofm_size: 9'd20,
                count_tiling: '0, read_ifm_size: 5'(size)};
        for (int i = 0; i < 3; i++) begin
            cfg.count_tiling = 14'(tile_list[i]);
            padded_window(9);
        end
        finish_test(name, errors_before);
    endtask

    task automatic test_phase_reset();
        int errors_before;
        errors_before = error_count;
        cfg = '{kernel_size: 2'd3, count_layer: 4'd2, ofm_size: 9'd20,
                count_tiling: 14'd5, read_ifm_size: 5'd16};
        clear_banks();
        repeat (5) write_row(1, random_row(), 1'b1);
        ofm_read_en = 1'b0;
        tick();                                     // window restarts at phase 0.
        repeat (4) write_row(1, random_row(), 1'b1);
        ofm_read_en = 1'b0;
        repeat (9) read_check(1);
        cfg.count_layer = 4'd1;
        padded_window(9);
        cfg.count_layer = 4'd2;
        cfg.ofm_size = 9'd12;                       // one tile per line.
        padded_window(9);
        finish_test("phase_reset", errors_before);
    endtask

    initial begin
        rst_n = 1'b0;
        cfg = '0;
        ofm_read_en = 1'b0;
        bank1 = '0;
        bank2 = '0;
        ifm_mux = 1'b0;
        data_in = '0;
        lcg_state = 53;
        run_len = 0;
        check_count = 0;
        error_count = 0;
        test_count = 0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("data_out", data_out.word, '0);
        test_masking();
        test_ping_pong();
        run_tiles("first_inner", 16, '{1, 5, 20});
        run_tiles("last_column", 6, '{21, 40, 30});
        test_phase_reset();
        if (dut0.u_pad_control.u_pad_checker.fail_count != 0) begin
            $display("assertion checker reported %0d failures",
                     dut0.u_pad_control.u_pad_checker.fail_count);
            error_count += dut0.u_pad_control.u_pad_checker.fail_count;
        end
        $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
source/ifm_buf_pkg.sv
source/ifm_pad_control.sv
source/ifm_pad_shaper.sv
source/ifm_lane_fifo.sv
source/ifm_fifo_array_top.sv
bench/ifm_pad_checker.sv
bench/tb_ifm_fifo_array.sv

// ==== Makefile ====
TOP := tb_ifm_fifo_array

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASS"

obj_dir/V$(TOP): sources.f $(wildcard source/*.sv bench/*.sv)
	verilator --binary --timing --top-module $(TOP) -f sources.f

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir
